//--- rtl/cfg_ctrl_pkg.sv
// Shared definitions for the register-configuration command controller
// Opcodes, FSM state encodings, table sizes and the packed structs between blocks
package cfg_ctrl_pkg;

    // Command payload limit in bytes
    localparam int MAX_CMD_BYTES = 8;
    localparam int BYTE_IDX_W    = $clog2(MAX_CMD_BYTES);

    // Register table geometry
    localparam int NUM_SLOTS  = 16;
    localparam int SLOT_W     = 4;
    // Port (2) + direction (1) + channel count (1)
    localparam int BANK_W     = 4;
    localparam int NUM_BANKS  = 2 ** BANK_W;
    // Bank, slot and byte select
    localparam int MEM_ADDR_W = BANK_W + SLOT_W + 1;
    localparam int REG_ADDR_W = 6;

    // Packet length field width
    localparam int LEN_W = 16;

    // Byte select inside a slot
    localparam logic SEL_VALUE = 1'b0;
    localparam logic SEL_TAG   = 1'b1;

    // DATA_REG carries a zero byte and then the value
    localparam logic [LEN_W-1:0] DATA_REG_LEN = 16'd2;

    typedef enum logic [7:0] {
        CMD_NONE          = 8'h00,
        CMD_GET_REG       = 8'h31,
        CMD_SET_REG       = 8'h32,
        CMD_DATA_REG      = 8'h90,
        CMD_ERR_NOT_FOUND = 8'hF0
    } cmd_op_e;

    typedef enum logic [2:0] {
        EX_IDLE,
        EX_READ,
        EX_LOOKUP,
        EX_WRITE_TAG,
        EX_WRITE_VAL,
        EX_REPLY
    } exec_state_e;

    typedef enum logic [1:0] {
        SR_IDLE,
        SR_READ,
        SR_CHECK
    } search_state_e;

    // Decoded inbound command
    typedef struct packed {
        cmd_op_e          id;
        logic [LEN_W-1:0] length;
        logic [1:0]       port;
        logic [7:0]       reg_addr;
        logic [7:0]       value;
    } cmd_t;

    // Result of one bank search
    typedef struct packed {
        logic              hit;
        logic              full;
        logic [SLOT_W-1:0] slot;
        logic [7:0]        value;
    } lookup_t;

    // Outbound reply
    typedef struct packed {
        cmd_op_e          id;
        logic [LEN_W-1:0] length;
        logic [7:0]       value;
    } reply_t;

endpackage

//--- rtl/cmd_reader.sv
// Inbound command reader
// Captures the header, counts payload bytes and builds the command struct
`timescale 1ns/1ps

module cmd_reader (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           start,
    input  logic                           ep4_ready,
    input  logic [7:0]                     ep4_cmd_id,
    input  logic [cfg_ctrl_pkg::LEN_W-1:0] ep4_cmd_length,
    input  logic [7:0]                     ep4_data,
    output logic                           ep4_read,
    output logic                           cmd_done,
    output cfg_ctrl_pkg::cmd_t             cmd
);

    logic                                        busy;
    logic                                        hdr_valid;
    logic                                        hdr_take;
    logic [cfg_ctrl_pkg::LEN_W-1:0]              count;
    logic [cfg_ctrl_pkg::LEN_W-1:0]              len_q;
    logic [7:0]                                  id_q;
    logic [cfg_ctrl_pkg::MAX_CMD_BYTES-1:0][7:0] payload;

    // Header is sampled on the first ready cycle after start
    assign hdr_take = busy && !hdr_valid && ep4_ready;

    // One byte per edge while the endpoint has data and bytes remain
    assign ep4_read = hdr_valid && ep4_ready && (count != len_q);
    // Zero-length packets finish right after the header
    assign cmd_done = hdr_valid && (count == len_q);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            busy      <= 1'b0;
            hdr_valid <= 1'b0;
            count     <= '0;
        end else begin
            if (start) begin
                busy <= 1'b1;
            end
            if (hdr_take) begin
                hdr_valid <= 1'b1;
                count     <= '0;
            end
            if (ep4_read) begin
                count <= count + 1'b1;
            end
            if (cmd_done) begin
                busy      <= 1'b0;
                hdr_valid <= 1'b0;
            end
        end
    end

    // Header and payload bytes, anything past the buffer is dropped
    always_ff @(posedge clk) begin
        if (hdr_take) begin
            id_q    <= ep4_cmd_id;
            len_q   <= ep4_cmd_length;
            payload <= '0;
        end else if (ep4_read && (count < cfg_ctrl_pkg::MAX_CMD_BYTES)) begin
            payload[count[cfg_ctrl_pkg::BYTE_IDX_W-1:0]] <= ep4_data;
        end
    end

    // Field map: port in byte 0, address in byte 1, value in byte 3
    always_comb begin
        cmd          = '0;
        cmd.id       = cfg_ctrl_pkg::cmd_op_e'(id_q);
        cmd.length   = len_q;
        cmd.port     = payload[0][1:0];
        cmd.reg_addr = payload[1];
        cmd.value    = payload[3];
    end

endmodule

//--- rtl/reg_table.sv
// Register table with configuration RAM, per-slot used flags
// and the sequential bank search engine
`timescale 1ns/1ps

module reg_table (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                search,
    input  logic [cfg_ctrl_pkg::BANK_W-1:0]     bank,
    input  logic [7:0]                          reg_addr,
    input  logic                                wr_en,
    input  logic [cfg_ctrl_pkg::MEM_ADDR_W-1:0] wr_addr,
    input  logic [7:0]                          wr_data,
    output logic                                done,
    output cfg_ctrl_pkg::lookup_t               lookup
);

    // Each slot holds a value byte and a tag byte
    logic [7:0] mem [2**cfg_ctrl_pkg::MEM_ADDR_W];
    logic [cfg_ctrl_pkg::NUM_BANKS-1:0][cfg_ctrl_pkg::NUM_SLOTS-1:0] used;

    cfg_ctrl_pkg::search_state_e          state;
    logic [cfg_ctrl_pkg::BANK_W-1:0]      bank_q;
    logic [cfg_ctrl_pkg::REG_ADDR_W-1:0]  addr_q;
    logic [cfg_ctrl_pkg::SLOT_W-1:0]      slot;
    logic                                 hit_q;
    logic [cfg_ctrl_pkg::MEM_ADDR_W-1:0]  rd_addr;
    logic [7:0]                           rd_data;
    logic                                 tag_match;
    logic                                 last_slot;
    logic                                 finish;

    // Tag read in READ, value byte of the same slot in CHECK
    assign rd_addr = {bank_q, slot,
                      (state == cfg_ctrl_pkg::SR_CHECK) ? cfg_ctrl_pkg::SEL_VALUE
                                                        : cfg_ctrl_pkg::SEL_TAG};

    assign tag_match = rd_data[cfg_ctrl_pkg::REG_ADDR_W-1:0] == addr_q;
    assign last_slot = slot == cfg_ctrl_pkg::SLOT_W'(cfg_ctrl_pkg::NUM_SLOTS - 1);

    // Done on a fetched value, a free slot, or the last slot missing
    assign finish = ((state == cfg_ctrl_pkg::SR_READ) && (hit_q || !used[bank_q][slot]))
                 || ((state == cfg_ctrl_pkg::SR_CHECK) && !tag_match && last_slot);

    // Synchronous single-port style RAM
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // A tag write claims the slot
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            used <= '0;
        end else if (wr_en && (wr_addr[0] == cfg_ctrl_pkg::SEL_TAG)) begin
            used[wr_addr[cfg_ctrl_pkg::MEM_ADDR_W-1 -: cfg_ctrl_pkg::BANK_W]]
                [wr_addr[cfg_ctrl_pkg::SLOT_W:1]] <= 1'b1;
        end
    end

    // Search FSM, two cycles per used slot
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= cfg_ctrl_pkg::SR_IDLE;
            slot  <= '0;
            hit_q <= 1'b0;
            done  <= 1'b0;
        end else begin
            done <= finish;
            case (state)
                cfg_ctrl_pkg::SR_IDLE: begin
                    if (search) begin
                        slot  <= '0;
                        hit_q <= 1'b0;
                        state <= cfg_ctrl_pkg::SR_READ;
                    end
                end
                cfg_ctrl_pkg::SR_READ: begin
                    state <= finish ? cfg_ctrl_pkg::SR_IDLE : cfg_ctrl_pkg::SR_CHECK;
                end
                cfg_ctrl_pkg::SR_CHECK: begin
                    if (tag_match) begin
                        // Value byte is being read this cycle
                        hit_q <= 1'b1;
                        state <= cfg_ctrl_pkg::SR_READ;
                    end else if (last_slot) begin
                        state <= cfg_ctrl_pkg::SR_IDLE;
                    end else begin
                        slot  <= slot + 1'b1;
                        state <= cfg_ctrl_pkg::SR_READ;
                    end
                end
                default: state <= cfg_ctrl_pkg::SR_IDLE;
            endcase
        end
    end

    // Search key and result
    always_ff @(posedge clk) begin
        if ((state == cfg_ctrl_pkg::SR_IDLE) && search) begin
            bank_q <= bank;
            addr_q <= reg_addr[cfg_ctrl_pkg::REG_ADDR_W-1:0];
        end
        if (finish) begin
            lookup.hit   <= (state == cfg_ctrl_pkg::SR_READ) && hit_q;
            lookup.full  <= (state == cfg_ctrl_pkg::SR_CHECK);
            lookup.slot  <= slot;
            lookup.value <= rd_data;
        end
    end

endmodule

//--- rtl/cmd_executor.sv
// Command sequencer
// Runs read, lookup, table write and reply for one command at a time
`timescale 1ns/1ps

module cmd_executor (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                cmd_done,
    input  cfg_ctrl_pkg::cmd_t                  cmd,
    input  logic                                done,
    input  cfg_ctrl_pkg::lookup_t               lookup,
    input  logic                                sent,
    input  logic [3:0]                          direction,
    input  logic [3:0]                          num_channels,
    output logic                                start,
    output logic                                search,
    output logic [cfg_ctrl_pkg::BANK_W-1:0]     bank,
    output logic [7:0]                          reg_addr,
    output logic                                wr_en,
    output logic [cfg_ctrl_pkg::MEM_ADDR_W-1:0] wr_addr,
    output logic [7:0]                          wr_data,
    output logic                                send,
    output cfg_ctrl_pkg::reply_t                reply
);

    cfg_ctrl_pkg::exec_state_e        state;
    cfg_ctrl_pkg::cmd_t               cmd_q;
    logic [cfg_ctrl_pkg::SLOT_W-1:0]  slot_q;
    logic                             is_tag;
    logic                             is_get;
    logic                             is_set;
    logic                             get_hit;

    // Bank from the command port and that port's direction and channel bits
    assign bank     = {cmd_q.port, direction[cmd_q.port], num_channels[cmd_q.port]};
    assign reg_addr = cmd_q.reg_addr;

    assign is_get  = cmd_q.id == cfg_ctrl_pkg::CMD_GET_REG;
    assign is_set  = cmd_q.id == cfg_ctrl_pkg::CMD_SET_REG;
    assign get_hit = is_get && lookup.hit;

    // Table writes straight from the state, tag first for a new entry
    assign is_tag  = state == cfg_ctrl_pkg::EX_WRITE_TAG;
    assign wr_en   = is_tag || (state == cfg_ctrl_pkg::EX_WRITE_VAL);
    assign wr_addr = {bank, slot_q, is_tag ? cfg_ctrl_pkg::SEL_TAG : cfg_ctrl_pkg::SEL_VALUE};
    // Tag byte: used marker, spare bit, address
    assign wr_data = is_tag ? {1'b1, 1'b0, cmd_q.reg_addr[cfg_ctrl_pkg::REG_ADDR_W-1:0]}
                            : cmd_q.value;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state  <= cfg_ctrl_pkg::EX_IDLE;
            start  <= 1'b0;
            search <= 1'b0;
            send   <= 1'b0;
        end else begin
            start  <= 1'b0;
            search <= 1'b0;
            send   <= 1'b0;
            case (state)
                cfg_ctrl_pkg::EX_IDLE: begin
                    start <= 1'b1;
                    state <= cfg_ctrl_pkg::EX_READ;
                end
                cfg_ctrl_pkg::EX_READ: begin
                    if (cmd_done) begin
                        if ((cmd.id == cfg_ctrl_pkg::CMD_GET_REG) ||
                            (cmd.id == cfg_ctrl_pkg::CMD_SET_REG)) begin
                            search <= 1'b1;
                            state  <= cfg_ctrl_pkg::EX_LOOKUP;
                        end else begin
                            // Unknown opcode is dropped
                            state <= cfg_ctrl_pkg::EX_IDLE;
                        end
                    end
                end
                cfg_ctrl_pkg::EX_LOOKUP: begin
                    if (done) begin
                        if (is_set && lookup.hit) begin
                            state <= cfg_ctrl_pkg::EX_WRITE_VAL;
                        end else if (is_set && !lookup.full) begin
                            state <= cfg_ctrl_pkg::EX_WRITE_TAG;
                        end else begin
                            // GET result or full bank
                            send  <= 1'b1;
                            state <= cfg_ctrl_pkg::EX_REPLY;
                        end
                    end
                end
                cfg_ctrl_pkg::EX_WRITE_TAG: state <= cfg_ctrl_pkg::EX_WRITE_VAL;
                cfg_ctrl_pkg::EX_WRITE_VAL: state <= cfg_ctrl_pkg::EX_IDLE;
                cfg_ctrl_pkg::EX_REPLY: begin
                    if (sent) begin
                        state <= cfg_ctrl_pkg::EX_IDLE;
                    end
                end
                default: state <= cfg_ctrl_pkg::EX_IDLE;
            endcase
        end
    end

    // Command, target slot and reply contents
    always_ff @(posedge clk) begin
        if ((state == cfg_ctrl_pkg::EX_READ) && cmd_done) begin
            cmd_q <= cmd;
        end
        if ((state == cfg_ctrl_pkg::EX_LOOKUP) && done) begin
            slot_q       <= lookup.slot;
            reply.id     <= get_hit ? cfg_ctrl_pkg::CMD_DATA_REG
                                    : cfg_ctrl_pkg::CMD_ERR_NOT_FOUND;
            reply.length <= get_hit ? cfg_ctrl_pkg::DATA_REG_LEN : '0;
            reply.value  <= lookup.value;
        end
    end

endmodule

//--- rtl/reply_writer.sv
// Outbound reply writer
// Holds the reply header and emits its bytes under endpoint back-pressure
`timescale 1ns/1ps

module reply_writer (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           send,
    input  cfg_ctrl_pkg::reply_t           reply,
    input  logic                           ep8_ready,
    output logic                           sent,
    output logic                           ep8_write,
    output logic [7:0]                     ep8_cmd_id,
    output logic [cfg_ctrl_pkg::LEN_W-1:0] ep8_cmd_length,
    output logic [7:0]                     ep8_data
);

    logic                           busy;
    logic [cfg_ctrl_pkg::LEN_W-1:0] remaining;
    cfg_ctrl_pkg::reply_t           reply_q;
    logic                           finish;

    // Header only visible while a reply is out
    assign ep8_cmd_id     = busy ? reply_q.id : cfg_ctrl_pkg::CMD_NONE;
    assign ep8_cmd_length = busy ? reply_q.length : '0;

    // One byte per ready cycle, value goes last
    assign ep8_write = busy && ep8_ready && (remaining != '0);
    assign ep8_data  = (remaining == cfg_ctrl_pkg::LEN_W'(1)) ? reply_q.value : 8'h00;

    // Last byte written, or empty reply on the first ready cycle
    assign finish = busy && ep8_ready && (remaining <= cfg_ctrl_pkg::LEN_W'(1));

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            busy      <= 1'b0;
            remaining <= '0;
            sent      <= 1'b0;
        end else begin
            sent <= finish;
            if (send) begin
                busy      <= 1'b1;
                remaining <= reply.length;
            end else begin
                if (ep8_write) begin
                    remaining <= remaining - 1'b1;
                end
                if (finish) begin
                    busy <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (send) begin
            reply_q <= reply;
        end
    end

endmodule

//--- rtl/cfg_ctrl_top.sv
// Top level of the register-configuration controller
// Connects reader, table, executor and reply writer
`timescale 1ns/1ps

module cfg_ctrl_top (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           ep4_ready,
    input  logic [7:0]                     ep4_cmd_id,
    input  logic [cfg_ctrl_pkg::LEN_W-1:0] ep4_cmd_length,
    input  logic [7:0]                     ep4_data,
    output logic                           ep4_read,
    input  logic                           ep8_ready,
    output logic                           ep8_write,
    output logic [7:0]                     ep8_cmd_id,
    output logic [cfg_ctrl_pkg::LEN_W-1:0] ep8_cmd_length,
    output logic [7:0]                     ep8_data,
    input  logic [3:0]                     direction,
    input  logic [3:0]                     num_channels
);

    // Reader handshake
    logic               start;
    logic               cmd_done;
    cfg_ctrl_pkg::cmd_t cmd;

    // Table access
    logic                                search;
    logic [cfg_ctrl_pkg::BANK_W-1:0]     bank;
    logic [7:0]                          reg_addr;
    logic                                wr_en;
    logic [cfg_ctrl_pkg::MEM_ADDR_W-1:0] wr_addr;
    logic [7:0]                          wr_data;
    logic                                done;
    cfg_ctrl_pkg::lookup_t               lookup;

    // Reply handshake
    logic                 send;
    logic                 sent;
    cfg_ctrl_pkg::reply_t reply;

    cmd_reader u_reader (.*);

    reg_table u_table (.*);

    cmd_executor u_exec (.*);

    reply_writer u_writer (.*);

endmodule

//--- tb/cfg_ctrl_asserts.sv
// Endpoint protocol assertions for the controller top level
// Attached to cfg_ctrl_top with bind
`timescale 1ns/1ps

module cfg_ctrl_asserts (
    input logic        clk,
    input logic        reset,
    input logic        ep4_ready,
    input logic        ep4_read,
    input logic        ep8_ready,
    input logic        ep8_write,
    input logic [7:0]  ep8_cmd_id,
    input logic [15:0] ep8_cmd_length,
    input logic [7:0]  ep8_data
);

    // Number of failed assertions so far
    int fail_count = 0;

    // Outbound bytes move only while the endpoint is ready
    assert property (@(posedge clk) disable iff (reset) ep8_write |-> ep8_ready)
        else begin
            $error("ep8_write without ep8_ready");
            fail_count++;
        end

    // Inbound reads only while the endpoint has data
    assert property (@(posedge clk) disable iff (reset) ep4_read |-> ep4_ready)
        else begin
            $error("ep4_read without ep4_ready");
            fail_count++;
        end

    // Reply id holds until the header clears
    assert property (@(posedge clk) disable iff (reset)
        (ep8_cmd_id != 8'h00) |=> (ep8_cmd_id == $past(ep8_cmd_id)) || (ep8_cmd_id == 8'h00))
        else begin
            $error("ep8_cmd_id changed during a reply");
            fail_count++;
        end

    assert property (@(posedge clk) disable iff (reset)
        !$isunknown({ep4_read, ep8_write, ep8_cmd_id, ep8_cmd_length, ep8_data}))
        else begin
            $error("unknown value on a DUT output");
            fail_count++;
        end

endmodule

bind cfg_ctrl_top cfg_ctrl_asserts u_asserts (
    .clk(clk), .reset(reset), .ep4_ready(ep4_ready), .ep4_read(ep4_read),
    .ep8_ready(ep8_ready), .ep8_write(ep8_write), .ep8_cmd_id(ep8_cmd_id),
    .ep8_cmd_length(ep8_cmd_length), .ep8_data(ep8_data)
);

//--- tb/cfg_ctrl_tb.sv
// Testbench for the register-configuration controller
// Packet driver, reply collector, reference model and directed tests
`timescale 1ns/1ps

module cfg_ctrl_tb;

    // About 100 commands at up to 150 cycles each with stalls and some margin
    localparam int MAX_CYCLES = 100 * 150 + 5000;
    // Longest search plus table writes fits well inside this
    localparam int WINDOW = 60;

    logic        clk;
    logic        reset;
    logic        ep4_ready;
    logic [7:0]  ep4_cmd_id;
    logic [15:0] ep4_cmd_length;
    logic [7:0]  ep4_data;
    logic        ep4_read;
    logic        ep8_ready;
    logic        ep8_write;
    logic [7:0]  ep8_cmd_id;
    logic [15:0] ep8_cmd_length;
    logic [7:0]  ep8_data;
    logic [3:0]  direction;
    logic [3:0]  num_channels;

    integer     seed;
    int         errors;
    int         tests;
    int         cycle_count;
    bit         stall;
    logic [3:0] cfg_dir;
    logic [3:0] cfg_nch;
    logic [7:0] pkt [12];
    // Reference model keyed by {bank, address bits 5:0} with an entry count per bank
    logic [7:0] model [int];
    int         bank_fill [16];

    cfg_ctrl_top DUT (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < MAX_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout after %0d cycles, the DUT stopped responding", cycle_count);
        $display("SOME TESTS FAILED");
        $finish;
    end

    task automatic check_val(input logic [31:0] actual, input logic [31:0] expected,
                             input string msg);
        if (actual !== expected) begin
            $display("ERR %0t ns: %s, got %0h expected %0h", $time, msg, actual, expected);
            errors++;
        end
    endtask

    // Bank follows the port and that port's direction and channel bits
    function automatic logic [3:0] bank_of(input logic [1:0] port);
        return {port, cfg_dir[port], cfg_nch[port]};
    endfunction

    task automatic set_cfg(input logic [3:0] dir, input logic [3:0] nch);
        @(posedge clk);
        cfg_dir = dir;
        cfg_nch = nch;
        direction    <= dir;
        num_channels <= nch;
    endtask

    // Header stays up and a new byte goes out after every sampled ep4_read
    task automatic feed_packet(input logic [7:0] id, input int len);
        int idx;
        idx = 0;
        @(posedge clk);
        ep4_cmd_id     <= id;
        ep4_cmd_length <= len[15:0];
        ep4_data       <= pkt[0];
        ep4_ready      <= 1'b1;
        while (idx < len) begin
            @(negedge clk);
            if (ep4_read) begin
                idx++;
            end
            @(posedge clk);
            ep4_data <= pkt[idx];
            // Random gaps between bytes when stalling
            ep4_ready <= (idx < len) && (!stall || (($random(seed) & 3) != 0));
        end
    endtask

    // Header must show within the window and bytes count until it clears
    task automatic collect_reply(output bit got, output logic [7:0] id,
                                 output logic [15:0] len, output int n,
                                 output logic [15:0] data);
        int waited;
        got = 1'b0;
        id = '0;
        len = '0;
        n = 0;
        data = '0;
        waited = 0;
        while (!(got && (ep8_cmd_id == 8'h00)) && (got || (waited < WINDOW))) begin
            @(posedge clk);
            ep8_ready <= !stall || ($random(seed) & 1);
            @(negedge clk);
            waited++;
            if (ep8_write) begin
                n++;
                data = {data[7:0], ep8_data};
            end
            if ((ep8_cmd_id != 8'h00) && !got) begin
                got = 1'b1;
                id  = ep8_cmd_id;
                len = ep8_cmd_length;
            end
        end
        // Writer holds any later reply until the next collect
        @(posedge clk);
        ep8_ready <= 1'b0;
    endtask

    // One command through the DUT with its reply compared against the model
    task automatic run_cmd(input logic [7:0] op, input logic [1:0] port,
                           input logic [7:0] addr, input logic [7:0] value, input int len);
        int          key;
        bit          exp_got;
        logic [7:0]  exp_id;
        logic [7:0]  exp_val;
        bit          got;
        logic [7:0]  id;
        logic [15:0] rlen;
        int          n;
        logic [15:0] data;
        key = {bank_of(port), addr[5:0]};
        exp_got = 1'b0;
        exp_id = 8'h00;
        exp_val = 8'h00;
        if (op == cfg_ctrl_pkg::CMD_GET_REG) begin
            exp_got = 1'b1;
            exp_id  = model.exists(key) ? 8'h90 : 8'hF0;
            exp_val = model.exists(key) ? model[key] : 8'h00;
        end else if (op == cfg_ctrl_pkg::CMD_SET_REG) begin
            if (model.exists(key)) begin
                model[key] = value;
            end else if (bank_fill[bank_of(port)] < 16) begin
                model[key] = value;
                bank_fill[bank_of(port)]++;
            end else begin
                // Full bank answers not found
                exp_got = 1'b1;
                exp_id  = 8'hF0;
            end
        end
        // Unused payload bytes and port byte upper bits are noise
        for (int i = 0; i < 12; i++) begin
            pkt[i] = $random(seed);
        end
        pkt[0][1:0] = port;
        pkt[1] = addr;
        pkt[3] = value;
        feed_packet(op, len);
        collect_reply(got, id, rlen, n, data);
        check_val(got, exp_got, "reply presence");
        if (exp_got && got) begin
            check_val(id, exp_id, "reply id");
            check_val(rlen, (exp_id == 8'h90) ? 2 : 0, "reply length");
            check_val(n, (exp_id == 8'h90) ? 2 : 0, "reply byte count");
            if (exp_id == 8'h90) begin
                check_val(data, {8'h00, exp_val}, "reply bytes");
            end
        end
    endtask

    task automatic finish_test(input string name, input int errs_before);
        tests++;
        $display("test %s %s", name, (errors == errs_before) ? "ok" : "mismatch");
    endtask

    task automatic get_on_empty_table();
        int e0;
        e0 = errors;
        @(negedge clk);
        check_val(ep8_cmd_id, 8'h00, "reply id after reset");
        run_cmd(cfg_ctrl_pkg::CMD_GET_REG, 2'd0, 8'h05, 8'h00, 4);
        finish_test("empty_get", e0);
    endtask

    task automatic set_then_get();
        int e0;
        e0 = errors;
        run_cmd(cfg_ctrl_pkg::CMD_SET_REG, 2'd0, 8'h12, 8'hA5, 4);
        run_cmd(cfg_ctrl_pkg::CMD_GET_REG, 2'd0, 8'h12, 8'h00, 4);
        // Overwrite of an existing entry
        run_cmd(cfg_ctrl_pkg::CMD_SET_REG, 2'd0, 8'h12, 8'h3C, 4);
        run_cmd(cfg_ctrl_pkg::CMD_GET_REG, 2'd0, 8'h12, 8'h00, 4);
        finish_test("set_get", e0);
    endtask

    task automatic bank_isolation();
        int e0;
        e0 = errors;
        set_cfg(4'b0101, 4'b0011);
        for (int p = 0; p < 4; p++) begin
            run_cmd(cfg_ctrl_pkg::CMD_SET_REG, p[1:0], 8'h20, 8'h40 + p[7:0], 4);
        end
        // Flipped direction and channel bits select four new banks
        set_cfg(4'b1010, 4'b1100);
        for (int p = 0; p < 4; p++) begin
            run_cmd(cfg_ctrl_pkg::CMD_SET_REG, p[1:0], 8'h20, 8'h50 + p[7:0], 4);
        end
        // Bits 7:6 of the address are ignored
        for (int p = 0; p < 4; p++) begin
            run_cmd(cfg_ctrl_pkg::CMD_GET_REG, p[1:0], 8'hE0, 8'h00, 4);
        end
        set_cfg(4'b0101, 4'b0011);
        for (int p = 0; p < 4; p++) begin
            run_cmd(cfg_ctrl_pkg::CMD_GET_REG, p[1:0], 8'h60, 8'h00, 4);
        end
        finish_test("banks", e0);
    endtask

    task automatic full_bank_reject();
        int         e0;
        logic [7:0] a;
        e0 = errors;
        a = 8'h00;
        set_cfg(4'b0000, 4'b0000);
        while (bank_fill[bank_of(2'd1)] < 16) begin
            run_cmd(cfg_ctrl_pkg::CMD_SET_REG, 2'd1, a, a ^ 8'h5A, 4);
            a++;
        end
        // Seventeenth address has nowhere to go
        run_cmd(cfg_ctrl_pkg::CMD_SET_REG, 2'd1, 8'h3F, 8'hEE, 4);
        run_cmd(cfg_ctrl_pkg::CMD_GET_REG, 2'd1, 8'h3F, 8'h00, 4);
        for (int i = 0; i < 16; i++) begin
            run_cmd(cfg_ctrl_pkg::CMD_GET_REG, 2'd1, i[7:0], 8'h00, 4);
        end
        finish_test("full_bank", e0);
    endtask

    task automatic unknown_opcode_skip();
        int e0;
        e0 = errors;
        run_cmd(8'h55, 2'd0, 8'h12, 8'h99, 4);
        run_cmd(cfg_ctrl_pkg::CMD_GET_REG, 2'd0, 8'h12, 8'h00, 4);
        finish_test("unknown_op", e0);
    endtask

    // Random traffic with stalls on both endpoints and packets up to 11 bytes
    task automatic random_traffic();
        int         e0;
        int         r;
        logic [7:0] op;
        e0 = errors;
        stall = 1'b1;
        set_cfg(4'b0110, 4'b1001);
        repeat (40) begin
            r = $random(seed);
            if (r[10:8] == 3'd0) begin
                set_cfg(r[3:0], r[7:4]);
            end
            op = r[11] ? cfg_ctrl_pkg::CMD_GET_REG : cfg_ctrl_pkg::CMD_SET_REG;
            // Few addresses per bank so hits are common
            run_cmd(op, r[13:12], r[23:16] & 8'hC7, r[31:24], 4 + (r[15:14] * 2) + r[4]);
        end
        stall = 1'b0;
        finish_test("random", e0);
    endtask

    initial begin
        seed = 26386;
        errors = 0;
        tests = 0;
        stall = 1'b0;
        cfg_dir = 4'h0;
        cfg_nch = 4'h0;
        reset = 1'b1;
        ep4_ready = 1'b0;
        ep4_cmd_id = 8'h00;
        ep4_cmd_length = 16'h0000;
        ep4_data = 8'h00;
        ep8_ready = 1'b0;
        direction = 4'h0;
        num_channels = 4'h0;
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        get_on_empty_table();
        set_then_get();
        bank_isolation();
        full_bank_reject();
        unknown_opcode_skip();
        random_traffic();
        // Protocol assertion failures count as errors
        errors = errors + DUT.u_asserts.fail_count;
        $display("tests run %0d, errors %0d", tests, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- cfg_ctrl.f
rtl/cfg_ctrl_pkg.sv
rtl/cmd_reader.sv
rtl/reg_table.sv
rtl/cmd_executor.sv
rtl/reply_writer.sv
rtl/cfg_ctrl_top.sv
tb/cfg_ctrl_asserts.sv
tb/cfg_ctrl_tb.sv

//--- Bender.yml
package:
  name: cfg_ctrl

sources:
  - rtl/cfg_ctrl_pkg.sv
  - rtl/cmd_reader.sv
  - rtl/reg_table.sv
  - rtl/cmd_executor.sv
  - rtl/reply_writer.sv
  - rtl/cfg_ctrl_top.sv
  - target: test
    files:
      - tb/cfg_ctrl_asserts.sv
      - tb/cfg_ctrl_tb.sv
